//--- common/pit_bus_pkg.sv
// Host bus package for the interval timer: data bytes, register addresses and control fields
`default_nettype none

package pit_bus_pkg;

	// One byte on the host data bus
	typedef logic [7:0] byte_t;

	// Register address from a1,a0
	typedef logic [1:0] addr_t;

	// Counter select field of a control word, bits 7:6
	typedef logic [1:0] sel_t;

	// Control words go to the last address
	localparam addr_t ADDR_CTRL = 2'd3;

	// Read/load field of a control word, bits 5:4
	// Zero is the counter latch command
	typedef enum logic [1:0] {
		rw_latch = 2'd0,
		rw_lsb   = 2'd1,
		rw_msb   = 2'd2,
		rw_both  = 2'd3
	} rw_e;

endpackage

`default_nettype wire

//--- common/pit_count_pkg.sv
// Counting package for the interval timer: count width, modes and engine states
`default_nettype none

package pit_count_pkg;

	// Counter value
	typedef logic [15:0] count_t;

	localparam int NUM_CHANNELS = 3;

	// A written count of zero counts the full range
	localparam count_t ZERO_LOAD = 16'hFFFF;

	// Flops in the counter clock synchronizer
	localparam int SYNC_STAGES = 2;

	// Mode field, bits 3:1 of a control word
	// Codes without a name count as mode_tc
	typedef enum logic [2:0] {
		mode_tc     = 3'd0,
		mode_rate   = 3'd2,
		mode_square = 3'd3
	} mode_e;

	typedef enum logic [1:0] {
		st_idle      = 2'd0,
		st_load_wait = 2'd1,
		st_count     = 2'd2
	} engine_state_e;

endpackage

`default_nettype wire

//--- common/pit_host_if.sv
// Interval timer host link: one channel's decoded host strobes and its next read byte
`default_nettype none
`timescale 1ns/100ps

interface pit_host_if;

	// Write data, valid while ctrl_wr or count_wr is high
	pit_bus_pkg::byte_t wr_data;

	// Control word addressed to this channel
	logic ctrl_wr;

	// Count byte written to this channel
	logic count_wr;

	// Read of this channel's address
	logic rd_stb;

	// Byte returned by the next read
	pit_bus_pkg::byte_t rd_byte;

	modport decoder (
		output wr_data,
		output ctrl_wr,
		output count_wr,
		output rd_stb,
		input  rd_byte
	);

	modport channel (
		input  wr_data,
		input  ctrl_wr,
		input  count_wr,
		input  rd_stb,
		output rd_byte
	);

endinterface

`default_nettype wire

//--- pit_counter/pit_count_engine.sv
// Count engine of one interval timer channel with counter clock sync, load/count FSM and out
`default_nettype none
`timescale 1ns/100ps

module pit_count_engine (
	input  wire                   ZCLK,
	input  wire                   rst_n,
	input  wire                   clk_in,
	input  wire                   gate,
	input  pit_count_pkg::mode_e  mode,
	input  wire                   new_mode,
	input  wire                   load_req,
	input  pit_count_pkg::count_t load_value,
	output pit_count_pkg::count_t count,
	output logic                  out
);

	logic [pit_count_pkg::SYNC_STAGES-1:0] sync_q;
	logic                                  clk_prev_q;
	logic                                  tick;
	logic                                  counting;
	pit_count_pkg::engine_state_e          state;
	pit_count_pkg::count_t                 start_value;
	pit_count_pkg::count_t                 reload_q;
	pit_count_pkg::count_t                 next_count;

	// Counter clock synchronizer and rising edge detect
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			sync_q     <= '0;
			clk_prev_q <= 1'b0;
		end else begin
			sync_q     <= {sync_q[pit_count_pkg::SYNC_STAGES-2:0], clk_in};
			clk_prev_q <= sync_q[pit_count_pkg::SYNC_STAGES-1];
		end
	end

	assign tick = sync_q[pit_count_pkg::SYNC_STAGES-1] & ~clk_prev_q;

	assign start_value = (load_value == '0) ? pit_count_pkg::ZERO_LOAD : load_value;
	assign counting    = (state == pit_count_pkg::st_count);

	// Loaded value kept for reloads and the square wave threshold
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			reload_q <= '0;
		end else if (state == pit_count_pkg::st_load_wait && tick) begin
			reload_q <= start_value;
		end
	end

	always_comb begin
		case (mode)
			pit_count_pkg::mode_rate,
			pit_count_pkg::mode_square: begin
				next_count = (count == 16'd1) ? reload_q : count - 16'd1;
			end
			// Terminal count stops at zero
			default: next_count = (count == '0) ? count : count - 16'd1;
		endcase
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= pit_count_pkg::st_idle;
			count <= '0;
		end else if (new_mode) begin
			state <= pit_count_pkg::st_idle;
		end else if (load_req) begin
			state <= pit_count_pkg::st_load_wait;
		end else begin
			case (state)
				pit_count_pkg::st_load_wait: begin
					if (tick) begin
						count <= start_value;
						state <= pit_count_pkg::st_count;
					end
				end
				pit_count_pkg::st_count: begin
					if (tick && gate) begin
						count <= next_count;
					end
				end
				default: ;
			endcase
		end
	end

	// Out follows the count in the same cycle
	always_comb begin
		case (mode)
			pit_count_pkg::mode_rate: begin
				out = ~(counting && count == 16'd1);
			end
			pit_count_pkg::mode_square: begin
				out = ~gate || ~counting || (count > (reload_q >> 1));
			end
			default: out = counting && (count == '0);
		endcase
	end

endmodule

`default_nettype wire

//--- pit_counter/pit_counter.sv
// One interval timer channel with its control register, count byte loading, latch and readback
`default_nettype none
`timescale 1ns/100ps

module pit_counter (
	input  wire          ZCLK,
	input  wire          rst_n,
	input  wire          clk_in,
	input  wire          gate,
	pit_host_if.channel  host,
	output logic         out
);

	pit_bus_pkg::rw_e      rw_q;
	pit_bus_pkg::rw_e      wr_rw;
	pit_count_pkg::mode_e  mode_q;
	pit_bus_pkg::byte_t    lsb_q;
	pit_bus_pkg::byte_t    msb_q;
	pit_count_pkg::count_t latch_q;
	pit_count_pkg::count_t count_now;
	logic                  wr_msb_next_q;
	logic                  rd_msb_q;
	logic                  latch_cmd;
	logic                  mode_wr;
	logic                  load_req;

	// Read/load field of the incoming control word
	assign wr_rw     = pit_bus_pkg::rw_e'(host.wr_data[5:4]);
	assign latch_cmd = host.ctrl_wr & (wr_rw == pit_bus_pkg::rw_latch);
	assign mode_wr   = host.ctrl_wr & (wr_rw != pit_bus_pkg::rw_latch);

	// Count is complete on a single-byte write or the second byte of a pair
	always_comb begin
		load_req = 1'b0;
		if (host.count_wr) begin
			case (rw_q)
				pit_bus_pkg::rw_lsb,
				pit_bus_pkg::rw_msb:  load_req = 1'b1;
				pit_bus_pkg::rw_both: load_req = wr_msb_next_q;
				default:              load_req = 1'b0;
			endcase
		end
	end

	// Control register
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			rw_q   <= pit_bus_pkg::rw_latch;
			mode_q <= pit_count_pkg::mode_tc;
		end else if (mode_wr) begin
			rw_q   <= wr_rw;
			mode_q <= pit_count_pkg::mode_e'(host.wr_data[3:1]);
		end
	end

	// A single-byte load clears the count byte it leaves out
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			lsb_q         <= '0;
			msb_q         <= '0;
			wr_msb_next_q <= 1'b0;
		end else if (mode_wr) begin
			wr_msb_next_q <= 1'b0;
		end else if (host.count_wr) begin
			case (rw_q)
				pit_bus_pkg::rw_lsb: begin
					lsb_q <= host.wr_data;
					msb_q <= '0;
				end
				pit_bus_pkg::rw_msb: begin
					lsb_q <= '0;
					msb_q <= host.wr_data;
				end
				pit_bus_pkg::rw_both: begin
					if (wr_msb_next_q) begin
						msb_q <= host.wr_data;
					end else begin
						lsb_q <= host.wr_data;
					end
					wr_msb_next_q <= ~wr_msb_next_q;
				end
				default: ;
			endcase
		end
	end

	// Count latch
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			latch_q <= '0;
		end else if (latch_cmd) begin
			latch_q <= count_now;
		end
	end

	// Read order alternates only for LSB then MSB
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_msb_q <= 1'b0;
		end else if (host.ctrl_wr) begin
			rd_msb_q <= 1'b0;
		end else if (host.rd_stb && rw_q == pit_bus_pkg::rw_both) begin
			rd_msb_q <= ~rd_msb_q;
		end
	end

	assign host.rd_byte = (rw_q == pit_bus_pkg::rw_msb ||
		(rw_q == pit_bus_pkg::rw_both && rd_msb_q)) ? latch_q[15:8] : latch_q[7:0];

	pit_count_engine u_engine (
		.ZCLK       (ZCLK),
		.rst_n      (rst_n),
		.clk_in     (clk_in),
		.gate       (gate),
		.mode       (mode_q),
		.new_mode   (mode_wr),
		.load_req   (load_req),
		.load_value ({msb_q, lsb_q}),
		.count      (count_now),
		.out        (out)
	);

endmodule

`default_nettype wire

//--- hw/pit_bus_decode.sv
// Interval timer bus decoder: per-channel host strobes and the registered read data
`default_nettype none
`timescale 1ns/100ps

module pit_bus_decode (
	input  wire                ZCLK,
	input  wire                rst_n,
	input  wire                cs_n,
	input  wire                rd_n,
	input  wire                wr_n,
	input  pit_bus_pkg::addr_t addr,
	input  pit_bus_pkg::byte_t d_in,
	output pit_bus_pkg::byte_t d_out,
	pit_host_if.decoder        host [pit_count_pkg::NUM_CHANNELS]
);

	logic host_wr;
	logic host_rd;
	logic ctrl_access;
	logic rd_count;
	pit_bus_pkg::sel_t sel;

	// Next read byte of each channel, gathered so it can be indexed
	pit_bus_pkg::byte_t rd_bytes [pit_count_pkg::NUM_CHANNELS];

	// A strobe only counts while the other one is idle
	assign host_wr     = ~cs_n & ~wr_n & rd_n;
	assign host_rd     = ~cs_n & ~rd_n & wr_n;
	assign ctrl_access = (addr == pit_bus_pkg::ADDR_CTRL);
	assign sel         = d_in[7:6];

	// Reads of the control address return nothing
	assign rd_count = host_rd & ~ctrl_access;

	for (genvar i = 0; i < pit_count_pkg::NUM_CHANNELS; i++) begin : g_strobe
		assign host[i].wr_data  = d_in;
		// Select value 3 matches no channel and is dropped here
		assign host[i].ctrl_wr  = host_wr & ctrl_access & (sel == pit_bus_pkg::sel_t'(i));
		assign host[i].count_wr = host_wr & (addr == pit_bus_pkg::addr_t'(i));
		assign host[i].rd_stb   = host_rd & (addr == pit_bus_pkg::addr_t'(i));
		assign rd_bytes[i]      = host[i].rd_byte;
	end

	// Read data is taken at the sampling edge and held until the next read
	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			d_out <= '0;
		end else if (rd_count) begin
			d_out <= rd_bytes[addr];
		end
	end

endmodule

`default_nettype wire

//--- hw/pit_top.sv
// Three-channel programmable interval timer, top level on a single ZCLK domain
`default_nettype none
`timescale 1ns/100ps

module pit_top (
	input  wire                                         ZCLK,
	input  wire                                         rst_n,
	input  wire                                         cs_n,
	input  wire                                         rd_n,
	input  wire                                         wr_n,
	input  wire                                         a1,
	input  wire                                         a0,
	input  wire         [pit_count_pkg::NUM_CHANNELS-1:0] gate,
	input  wire         [pit_count_pkg::NUM_CHANNELS-1:0] clk,
	input  pit_bus_pkg::byte_t                          d_in,
	output pit_bus_pkg::byte_t                          d_out,
	output logic        [pit_count_pkg::NUM_CHANNELS-1:0] out
);

	// Decoded host strobes, one link per channel
	pit_host_if host_if [pit_count_pkg::NUM_CHANNELS] ();

	pit_bus_decode u_bus_decode (
		.ZCLK  (ZCLK),
		.rst_n (rst_n),
		.cs_n  (cs_n),
		.rd_n  (rd_n),
		.wr_n  (wr_n),
		.addr  ({a1, a0}),
		.d_in  (d_in),
		.d_out (d_out),
		.host  (host_if)
	);

	for (genvar i = 0; i < pit_count_pkg::NUM_CHANNELS; i++) begin : g_channel
		pit_counter u_counter (
			.ZCLK   (ZCLK),
			.rst_n  (rst_n),
			.clk_in (clk[i]),
			.gate   (gate[i]),
			.host   (host_if[i]),
			.out    (out[i])
		);
	end

endmodule

`default_nettype wire

//--- sim/pit_assertions.sv
// Interval timer assertions: host strobe overlap, out after reset and held read data
`default_nettype none
`timescale 1ns/100ps

module pit_assertions (
	input wire                                  ZCLK,
	input wire                                  rst_n,
	input wire                                  cs_n,
	input wire                                  rd_n,
	input wire                                  wr_n,
	input pit_bus_pkg::byte_t                   d_out,
	input wire [pit_count_pkg::NUM_CHANNELS-1:0] out
);

	// Read and write never overlap in a selected access
	a_one_strobe: assert property (@(posedge ZCLK) disable iff (!rst_n)
		!(!cs_n && !rd_n && !wr_n))
		else $error("Read and write strobes low together");

	a_out_after_reset: assert property (@(posedge ZCLK)
		$rose(rst_n) |-> (out == '0))
		else $error("Out not low after reset release");

	// Read data only moves on the edge that samples a read
	a_dout_hold: assert property (@(posedge ZCLK) disable iff (!rst_n)
		$changed(d_out) |-> $past(!cs_n && !rd_n))
		else $error("d_out changed without a read");

endmodule

`default_nettype wire

//--- sim/tb_pit.sv
// Testbench for the interval timer driving random programming and counter clock pulses
`default_nettype none
`timescale 1ns/100ps

module tb_pit;

	localparam int NCH        = pit_count_pkg::NUM_CHANNELS;
	localparam int NUM_TESTS  = 24;
	localparam int MAX_PULSES = 80;
	// Longest test is 80 pulses of 8 cycles, plus latch reads and programming
	localparam int TEST_CYCLES = MAX_PULSES * 8 + 250;
	localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 200;

	logic               ZCLK = 1'b0;
	logic               rst_n;
	logic               cs_n;
	logic               rd_n;
	logic               wr_n;
	logic               a1;
	logic               a0;
	logic [NCH-1:0]     gate;
	logic [NCH-1:0]     clk;
	pit_bus_pkg::byte_t d_in;
	pit_bus_pkg::byte_t d_out;
	logic [NCH-1:0]     out;

	integer seed = 57368;
	int     cycles = 0;

	// Reference model with one entry per channel
	pit_count_pkg::mode_e         m_mode [NCH];
	pit_bus_pkg::rw_e             m_rw [NCH];
	pit_bus_pkg::byte_t           m_lsb [NCH];
	pit_bus_pkg::byte_t           m_msb [NCH];
	pit_count_pkg::count_t        m_reload [NCH];
	pit_count_pkg::count_t        m_count [NCH];
	pit_count_pkg::count_t        m_latch [NCH];
	pit_count_pkg::engine_state_e m_state [NCH];
	logic                         m_wr_msb [NCH];
	logic                         m_rd_msb [NCH];

	pit_top uut (
		.ZCLK  (ZCLK),
		.rst_n (rst_n),
		.cs_n  (cs_n),
		.rd_n  (rd_n),
		.wr_n  (wr_n),
		.a1    (a1),
		.a0    (a0),
		.gate  (gate),
		.clk   (clk),
		.d_in  (d_in),
		.d_out (d_out),
		.out   (out)
	);

	bind pit_top pit_assertions u_assertions (
		.ZCLK  (ZCLK),
		.rst_n (rst_n),
		.cs_n  (cs_n),
		.rd_n  (rd_n),
		.wr_n  (wr_n),
		.d_out (d_out),
		.out   (out)
	);

	always #2 ZCLK = ~ZCLK;

	always @(posedge ZCLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d ZCLK cycles", CYCLE_LIMIT);
			report_failure();
		end
	end

	task automatic report_failure();
		$display("Checks failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_byte(string name, pit_bus_pkg::byte_t got, pit_bus_pkg::byte_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_out(logic [NCH-1:0] got, logic [NCH-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED out: got 0x%01h, expected 0x%01h", got, exp);
			report_failure();
		end
	endtask

	function automatic int draw(int n);
		int r;
		r = $random(seed);
		return int'($unsigned(r) % $unsigned(n));
	endfunction

	function automatic logic model_out(int c, logic g);
		logic counting;
		counting = (m_state[c] == pit_count_pkg::st_count);
		case (m_mode[c])
			pit_count_pkg::mode_rate:   return !(counting && m_count[c] == 16'd1);
			pit_count_pkg::mode_square: begin
				return !g || !counting || (m_count[c] > (m_reload[c] >> 1));
			end
			default:                    return counting && m_count[c] == 16'd0;
		endcase
	endfunction

	// One counter clock tick on channel c
	function automatic void model_tick(int c, logic g);
		pit_count_pkg::count_t loaded;
		if (m_state[c] == pit_count_pkg::st_load_wait) begin
			loaded = {m_msb[c], m_lsb[c]};
			if (loaded == 16'd0) begin
				loaded = pit_count_pkg::ZERO_LOAD;
			end
			m_reload[c] = loaded;
			m_count[c]  = loaded;
			m_state[c]  = pit_count_pkg::st_count;
		end else if (m_state[c] == pit_count_pkg::st_count && g) begin
			if (m_mode[c] == pit_count_pkg::mode_rate ||
				m_mode[c] == pit_count_pkg::mode_square) begin
				m_count[c] = (m_count[c] == 16'd1) ? m_reload[c] : m_count[c] - 16'd1;
			end else if (m_count[c] != 16'd0) begin
				m_count[c] = m_count[c] - 16'd1;
			end
		end
	endfunction

	function automatic void model_reset();
		for (int c = 0; c < NCH; c++) begin
			m_mode[c]   = pit_count_pkg::mode_tc;
			m_rw[c]     = pit_bus_pkg::rw_latch;
			m_lsb[c]    = '0;
			m_msb[c]    = '0;
			m_reload[c] = '0;
			m_count[c]  = '0;
			m_latch[c]  = '0;
			m_state[c]  = pit_count_pkg::st_idle;
			m_wr_msb[c] = 1'b0;
			m_rd_msb[c] = 1'b0;
		end
	endfunction

	// Starts and ends 1 ns after a rising edge and includes the idle cycle
	task automatic bus_write(pit_bus_pkg::addr_t addr, pit_bus_pkg::byte_t data);
		{a1, a0} = addr;
		d_in = data;
		cs_n = 1'b0;
		wr_n = 1'b0;
		@(posedge ZCLK);
		#1;
		cs_n = 1'b1;
		wr_n = 1'b1;
		@(posedge ZCLK);
		#1;
	endtask

	task automatic write_control(int c, pit_bus_pkg::rw_e rw, pit_count_pkg::mode_e mode);
		bus_write(pit_bus_pkg::ADDR_CTRL, {pit_bus_pkg::sel_t'(c), rw, mode, 1'b0});
		if (rw == pit_bus_pkg::rw_latch) begin
			m_latch[c] = m_count[c];
		end else begin
			m_rw[c]     = rw;
			m_mode[c]   = mode;
			m_state[c]  = pit_count_pkg::st_idle;
			m_wr_msb[c] = 1'b0;
		end
		m_rd_msb[c] = 1'b0;
	endtask

	task automatic write_count(int c, pit_bus_pkg::byte_t data);
		bus_write(pit_bus_pkg::addr_t'(c), data);
		case (m_rw[c])
			pit_bus_pkg::rw_lsb: begin
				m_lsb[c]   = data;
				m_msb[c]   = '0;
				m_state[c] = pit_count_pkg::st_load_wait;
			end
			pit_bus_pkg::rw_msb: begin
				m_lsb[c]   = '0;
				m_msb[c]   = data;
				m_state[c] = pit_count_pkg::st_load_wait;
			end
			pit_bus_pkg::rw_both: begin
				if (m_wr_msb[c]) begin
					m_msb[c]   = data;
					m_state[c] = pit_count_pkg::st_load_wait;
				end else begin
					m_lsb[c] = data;
				end
				m_wr_msb[c] = !m_wr_msb[c];
			end
			default: ;
		endcase
	endtask

	task automatic read_check(int c);
		pit_bus_pkg::byte_t exp;
		{a1, a0} = pit_bus_pkg::addr_t'(c);
		cs_n = 1'b0;
		rd_n = 1'b0;
		@(posedge ZCLK);
		#1;
		cs_n = 1'b1;
		rd_n = 1'b1;
		if (m_rw[c] == pit_bus_pkg::rw_msb ||
			(m_rw[c] == pit_bus_pkg::rw_both && m_rd_msb[c])) begin
			exp = m_latch[c][15:8];
		end else begin
			exp = m_latch[c][7:0];
		end
		check_byte("d_out", d_out, exp);
		if (m_rw[c] == pit_bus_pkg::rw_both) begin
			m_rd_msb[c] = !m_rd_msb[c];
		end
		@(posedge ZCLK);
		#1;
	endtask

	task automatic latch_and_read(int c);
		write_control(c, pit_bus_pkg::rw_latch, pit_count_pkg::mode_tc);
		read_check(c);
		if (m_rw[c] == pit_bus_pkg::rw_both) begin
			read_check(c);
		end
	endtask

	task automatic check_all_out();
		logic [NCH-1:0] exp;
		for (int c = 0; c < NCH; c++) begin
			exp[c] = model_out(c, gate[c]);
		end
		check_out(out, exp);
	endtask

	// Counter clock is high 4 cycles and low 4 with the tick landing 3 cycles in
	task automatic pulse(logic [NCH-1:0] g);
		gate = g;
		clk  = '1;
		repeat (4) @(posedge ZCLK);
		#1;
		clk = '0;
		repeat (2) @(posedge ZCLK);
		#1;
		for (int c = 0; c < NCH; c++) begin
			model_tick(c, g[c]);
		end
		check_all_out();
		repeat (2) @(posedge ZCLK);
		#1;
	endtask

	task automatic run_test();
		int                   c;
		int                   n;
		int                   r;
		logic                 gated;
		pit_bus_pkg::rw_e     rw;
		pit_count_pkg::mode_e mode;
		logic [NCH-1:0]       g;
		c = draw(NCH);
		r = draw(3);
		mode = (r == 0) ? pit_count_pkg::mode_tc :
			(r == 1) ? pit_count_pkg::mode_rate : pit_count_pkg::mode_square;
		rw    = pit_bus_pkg::rw_e'(draw(3) + 1);
		n     = 2 + draw(39);
		gated = (draw(4) == 0);
		write_control(c, rw, mode);
		write_count(c, pit_bus_pkg::byte_t'(n));
		if (rw == pit_bus_pkg::rw_both) begin
			write_count(c, 8'h00);
		end
		check_all_out();
		for (int p = 0; p < 2 * n; p++) begin
			r = draw(8);
			g = r[NCH-1:0];
			// The programmed channel sees a random gate only in gated tests
			if (!gated) begin
				g[c] = 1'b1;
			end
			pulse(g);
			if (p % 5 == 2) begin
				latch_and_read(c);
			end else if (p % 5 == 4) begin
				latch_and_read(draw(NCH));
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		cs_n  = 1'b1;
		rd_n  = 1'b1;
		wr_n  = 1'b1;
		a1    = 1'b0;
		a0    = 1'b0;
		d_in  = '0;
		gate  = '0;
		clk   = '0;
		model_reset();
		repeat (3) @(posedge ZCLK);
		#1;
		rst_n = 1'b1;
		@(posedge ZCLK);
		#1;
		check_out(out, '0);
		for (int c = 0; c < NCH; c++) begin
			latch_and_read(c);
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test();
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/pit_bus_pkg.sv
common/pit_count_pkg.sv
common/pit_host_if.sv
pit_counter/pit_count_engine.sv
pit_counter/pit_counter.sv
hw/pit_bus_decode.sv
hw/pit_top.sv
sim/pit_assertions.sv
sim/tb_pit.sv

//--- Makefile
# Verilator build for the interval timer testbench

VERILATOR ?= verilator
TOP       ?= tb_pit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
